// ==== rtl/dcache_pkg.sv ====
`default_nettype none

package dcache_pkg;

    localparam int ADDR_W     = 32;
    localparam int DATA_W     = 32;
    localparam int LINE_WORDS = 8;
    localparam int WAYS       = 2;

    localparam int OFF_W    = $clog2(LINE_WORDS); // word select inside a line
    localparam int LINE_B_W = OFF_W + 2;          // byte offset bits of a line

    typedef logic [ADDR_W-1:0]   addr_t;
    typedef logic [DATA_W-1:0]   word_t;
    typedef logic [DATA_W/8-1:0] strb_t; // zero mask means load

    typedef enum logic [2:0] {
        ST_IDLE      = 3'd0,
        ST_LOOKUP    = 3'd1,
        ST_WRITEBACK = 3'd2,
        ST_REFILL    = 3'd3,
        ST_REPLY     = 3'd4
    } ctrl_state_e;

endpackage

`default_nettype wire

// ==== rtl/dcache_tag_store.sv ====
`default_nettype none

module dcache_tag_store
    import dcache_pkg::*;
#(
    parameter int INDEX_W = 4,
    localparam int TAG_W = ADDR_W - INDEX_W - LINE_B_W
) (
    input  logic             clk,
    input  logic             rst,
    input  addr_t            addr,
    input  logic             lookup_en,
    input  logic             fill_en,
    input  logic             fill_way,
    input  logic             store_en,
    input  logic             lru_touch,
    output logic             hit,
    output logic             hit_way,
    output logic             victim_way,
    output logic             victim_dirty,
    output logic [TAG_W-1:0] victim_tag
);

    localparam int SETS = 1 << INDEX_W;

    logic [TAG_W-1:0] tag_arr [WAYS][SETS];
    logic [SETS-1:0]  valid_arr [WAYS];
    logic [SETS-1:0]  dirty_arr [WAYS];
    logic [SETS-1:0]  lru_arr;  // way to evict next, per index

    logic [TAG_W-1:0]   rd_tag [WAYS];
    logic [WAYS-1:0]    rd_valid;
    logic [WAYS-1:0]    rd_dirty;
    logic               rd_lru;
    logic [WAYS-1:0]    hit_vec;
    logic [TAG_W-1:0]   req_tag;
    logic [INDEX_W-1:0] idx;

    assign req_tag = addr[ADDR_W-1:INDEX_W+LINE_B_W];
    assign idx     = addr[INDEX_W+LINE_B_W-1:LINE_B_W];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int w = 0; w < WAYS; w++) begin
                for (int s = 0; s < SETS; s++) begin
                    tag_arr[w][s] <= '0;
                end
                valid_arr[w] <= '0;
                dirty_arr[w] <= '0;
            end
            lru_arr <= '0;
        end else begin
            if (fill_en) begin
                tag_arr[fill_way][idx]   <= req_tag;
                valid_arr[fill_way][idx] <= 1'b1;
                dirty_arr[fill_way][idx] <= 1'b0; // fresh line from memory
            end
            // fill_way carries the hit way on a hit, the filled way on a miss
            if (store_en) begin
                dirty_arr[fill_way][idx] <= 1'b1;
            end
            if (fill_en || lru_touch) begin
                lru_arr[idx] <= ~fill_way;
            end
        end
    end

    // synchronous read of both ways
    always_ff @(posedge clk) begin
        if (lookup_en) begin
            for (int w = 0; w < WAYS; w++) begin
                rd_tag[w]   <= tag_arr[w][idx];
                rd_valid[w] <= valid_arr[w][idx];
                rd_dirty[w] <= dirty_arr[w][idx];
            end
            rd_lru <= lru_arr[idx];
        end
    end

    always_comb begin
        for (int w = 0; w < WAYS; w++) begin
            hit_vec[w] = rd_valid[w] && (rd_tag[w] == req_tag);
        end
    end

    assign hit          = |hit_vec;
    assign hit_way      = hit_vec[1];
    assign victim_way   = rd_lru;
    assign victim_dirty = rd_valid[rd_lru] & rd_dirty[rd_lru]; // only valid lines go back
    assign victim_tag   = rd_tag[rd_lru];

endmodule

`default_nettype wire

// ==== rtl/dcache_data_store.sv ====
`default_nettype none

module dcache_data_store
    import dcache_pkg::*;
#(
    parameter int INDEX_W = 4
) (
    input  logic             clk,
    input  addr_t            addr,
    input  logic             lookup_en,
    input  logic             store_en,
    input  logic             hit_way,
    input  strb_t            strb,
    input  word_t            wdata,
    input  logic             beat_valid,
    input  logic [OFF_W-1:0] beat_idx,
    input  word_t            beat_data,
    input  logic             fill_way,
    input  logic [OFF_W-1:0] wb_idx,
    output word_t            hit_word,
    output word_t            wb_word
);

    localparam int SETS = 1 << INDEX_W;

    word_t mem [WAYS][SETS][LINE_WORDS];
    word_t rd_line [WAYS][LINE_WORDS]; // whole line of both ways

    logic [INDEX_W-1:0] idx;
    logic [OFF_W-1:0]   off;
    word_t              fill_word;

    assign idx = addr[INDEX_W+LINE_B_W-1:LINE_B_W];
    assign off = addr[LINE_B_W-1:2];

    // store bytes ride on top of the requested beat
    always_comb begin
        fill_word = beat_data;
        if (beat_idx == off) begin
            for (int b = 0; b < DATA_W/8; b++) begin
                if (strb[b]) begin
                    fill_word[8*b +: 8] = wdata[8*b +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (beat_valid) begin
            mem[fill_way][idx][beat_idx] <= fill_word;
        end
        if (store_en) begin
            for (int b = 0; b < DATA_W/8; b++) begin
                if (strb[b]) begin
                    mem[fill_way][idx][off][8*b +: 8] <= wdata[8*b +: 8];
                end
            end
        end
        if (lookup_en) begin
            for (int w = 0; w < WAYS; w++) begin
                rd_line[w] <= mem[w][idx];
            end
        end
    end

    assign hit_word = rd_line[hit_way][off];
    assign wb_word  = rd_line[fill_way][wb_idx]; // victim snapshot from lookup

endmodule

`default_nettype wire

// ==== rtl/dcache_ctrl.sv ====
`default_nettype none

module dcache_ctrl
    import dcache_pkg::*;
(
    input  logic             clk,
    input  logic             rst,
    input  logic             req,
    input  strb_t            strb,
    input  addr_t            addr,
    input  logic             hit,
    input  logic             hit_way,
    input  logic             victim_way,
    input  logic             victim_dirty,
    input  logic             wb_done,
    input  logic             rf_done,
    input  logic             beat_valid,
    input  logic [OFF_W-1:0] beat_idx,
    input  word_t            hit_word,
    input  word_t            beat_data,
    output logic             ack,
    output word_t            rdata,
    output logic             lookup_en,
    output logic             fill_en,
    output logic             fill_way,
    output logic             store_en,
    output logic             lru_touch,
    output logic             wb_start,
    output logic             rf_start
);

    ctrl_state_e      state;
    ctrl_state_e      state_nx;
    logic             way_r;    // way in use for this request
    logic             is_store;
    logic [OFF_W-1:0] off;

    assign is_store = |strb;
    assign off      = addr[LINE_B_W-1:2];
    assign fill_way = way_r;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_IDLE;
            ack   <= 1'b0;
        end else begin
            state <= state_nx;
            if (state == ST_REPLY) begin
                ack <= 1'b1;
            end else if (state == ST_IDLE && !req) begin
                ack <= 1'b0; // core has let go
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == ST_LOOKUP) begin
            way_r <= hit ? hit_way : victim_way; // held through write-back and refill
            if (hit) begin
                rdata <= hit_word;
            end
        end
        if (state == ST_REFILL && beat_valid && beat_idx == off) begin
            rdata <= beat_data;
        end
    end

    always_comb begin
        state_nx  = state;
        lookup_en = 1'b0;
        fill_en   = 1'b0;
        store_en  = 1'b0;
        lru_touch = 1'b0;
        wb_start  = 1'b0;
        rf_start  = 1'b0;
        case (state)
            ST_IDLE: begin
                if (req && !ack) begin
                    lookup_en = 1'b1;
                    state_nx  = ST_LOOKUP;
                end
            end
            ST_LOOKUP: begin
                if (hit) begin
                    state_nx = ST_REPLY;
                end else if (victim_dirty) begin
                    wb_start = 1'b1;
                    state_nx = ST_WRITEBACK;
                end else begin
                    rf_start = 1'b1;
                    state_nx = ST_REFILL;
                end
            end
            ST_WRITEBACK: begin
                if (wb_done) begin
                    rf_start = 1'b1;
                    state_nx = ST_REFILL;
                end
            end
            ST_REFILL: begin
                if (rf_done) begin
                    fill_en  = 1'b1;
                    state_nx = ST_REPLY;
                end
            end
            ST_REPLY: begin
                store_en  = is_store; // also marks a refilled line dirty
                lru_touch = hit;      // a miss already moved lru on fill
                state_nx  = ST_IDLE;
            end
            default: state_nx = ST_IDLE;
        endcase
    end

    // core keeps the address steady until the cache answers
    a_req_addr_hold: assert property (
        @(posedge clk) disable iff (rst)
        (req && !ack && $past(req && !ack)) |-> $stable(addr)
    );

endmodule

`default_nettype wire

// ==== rtl/dcache_axi_master.sv ====
`default_nettype none

module dcache_axi_master
    import dcache_pkg::*;
#(
    parameter int INDEX_W = 4,
    localparam int TAG_W = ADDR_W - INDEX_W - LINE_B_W
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             wb_start,
    input  logic             rf_start,
    input  logic [TAG_W-1:0] victim_tag,
    input  addr_t            addr,
    input  word_t            wb_word,
    output logic [OFF_W-1:0] wb_idx,
    output logic             wb_done,
    output logic             rf_done,
    output logic             beat_valid,
    output logic [OFF_W-1:0] beat_idx,
    output word_t            beat_data,
    output addr_t            araddr,
    output logic [7:0]       arlen,
    output logic             arvalid,
    input  logic             arready,
    input  word_t            rdata_m,
    input  logic             rlast,
    input  logic             rvalid,
    output logic             rready,
    output addr_t            awaddr,
    output logic [7:0]       awlen,
    output logic             awvalid,
    input  logic             awready,
    output word_t            wdata_m,
    output strb_t            wstrb,
    output logic             wlast,
    output logic             wvalid,
    input  logic             wready,
    input  logic             bvalid,
    output logic             bready
);

    logic             ar_pend, r_act;
    logic             aw_pend, w_act, b_wait;
    logic [OFF_W-1:0] rcnt, wcnt;  // beat counters
    logic             ar_hs, r_hs, aw_hs, w_hs, b_hs;

    assign ar_hs = arvalid && arready;
    assign r_hs  = rvalid && rready;
    assign aw_hs = awvalid && awready;
    assign w_hs  = wvalid && wready;
    assign b_hs  = bvalid && bready;

    always_ff @(posedge clk) begin
        if (rst) begin
            ar_pend <= 1'b0;
            r_act   <= 1'b0;
            rcnt    <= '0;
        end else begin
            if (rf_start) begin
                ar_pend <= 1'b1;
            end else if (ar_hs) begin
                ar_pend <= 1'b0;
            end
            if (ar_hs) begin
                r_act <= 1'b1;
            end else if (rf_done) begin
                r_act <= 1'b0;
            end
            if (rf_done) begin
                rcnt <= '0;
            end else if (r_hs) begin
                rcnt <= rcnt + OFF_W'(1);
            end
        end
    end

    // write data follows the aw handshake
    always_ff @(posedge clk) begin
        if (rst) begin
            aw_pend <= 1'b0;
            w_act   <= 1'b0;
            b_wait  <= 1'b0;
            wcnt    <= '0;
        end else begin
            if (wb_start) begin
                aw_pend <= 1'b1;
            end else if (aw_hs) begin
                aw_pend <= 1'b0;
            end
            if (aw_hs) begin
                w_act <= 1'b1;
            end else if (w_hs && wlast) begin
                w_act <= 1'b0;
            end
            if (w_hs && wlast) begin
                b_wait <= 1'b1;
            end else if (b_hs) begin
                b_wait <= 1'b0;
            end
            if (w_hs) begin
                wcnt <= wlast ? '0 : wcnt + OFF_W'(1);
            end
        end
    end

    assign araddr  = {addr[ADDR_W-1:LINE_B_W], {LINE_B_W{1'b0}}}; // line aligned
    assign arlen   = 8'(LINE_WORDS - 1);
    assign arvalid = ar_pend;
    assign rready  = r_act;

    assign awaddr  = {victim_tag, addr[INDEX_W+LINE_B_W-1:LINE_B_W], {LINE_B_W{1'b0}}};
    assign awlen   = 8'(LINE_WORDS - 1);
    assign awvalid = aw_pend;
    assign wdata_m = wb_word;
    assign wstrb   = '1;          // whole line goes back
    assign wlast   = (wcnt == OFF_W'(LINE_WORDS - 1));
    assign wvalid  = w_act;
    assign bready  = b_wait;

    assign wb_idx     = wcnt;
    assign wb_done    = b_hs;
    assign beat_valid = r_hs;
    assign beat_idx   = rcnt;
    assign beat_data  = rdata_m;
    assign rf_done    = r_hs && rlast;

    // a raised valid waits for its ready with its payload held
    a_ar_hold: assert property (
        @(posedge clk) disable iff (rst)
        (arvalid && !arready) |=> (arvalid && $stable(araddr))
    );
    a_aw_hold: assert property (
        @(posedge clk) disable iff (rst)
        (awvalid && !awready) |=> (awvalid && $stable(awaddr))
    );
    a_w_hold: assert property (
        @(posedge clk) disable iff (rst)
        (wvalid && !wready) |=> (wvalid && $stable(wdata_m))
    );

endmodule

`default_nettype wire

// ==== rtl/dcache_top.sv ====
`default_nettype none

module dcache_top
    import dcache_pkg::*;
#(
    parameter int INDEX_W = 4
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       req,
    input  strb_t      strb,
    input  addr_t      addr,
    input  word_t      wdata,
    output logic       ack,
    output word_t      rdata,
    output addr_t      araddr,
    output logic [7:0] arlen,
    output logic       arvalid,
    input  logic       arready,
    input  word_t      rdata_m,
    input  logic       rlast,
    input  logic       rvalid,
    output logic       rready,
    output addr_t      awaddr,
    output logic [7:0] awlen,
    output logic       awvalid,
    input  logic       awready,
    output word_t      wdata_m,
    output strb_t      wstrb,
    output logic       wlast,
    output logic       wvalid,
    input  logic       wready,
    input  logic       bvalid,
    output logic       bready
);

    localparam int TAG_W = ADDR_W - INDEX_W - LINE_B_W;

    logic             lookup_en, fill_en, fill_way, store_en, lru_touch;
    logic             wb_start, rf_start, wb_done, rf_done;
    logic             hit, hit_way, victim_way, victim_dirty;
    logic [TAG_W-1:0] victim_tag;
    logic             beat_valid;
    logic [OFF_W-1:0] beat_idx, wb_idx;
    word_t            beat_data, hit_word, wb_word;

    dcache_ctrl u_ctrl (
        .clk, .rst, .req, .strb, .addr,
        .hit, .hit_way, .victim_way, .victim_dirty,
        .wb_done, .rf_done, .beat_valid, .beat_idx, .hit_word, .beat_data,
        .ack, .rdata, .lookup_en, .fill_en, .fill_way, .store_en, .lru_touch,
        .wb_start, .rf_start
    );

    dcache_tag_store #(.INDEX_W(INDEX_W)) u_tag_store (
        .clk, .rst, .addr, .lookup_en, .fill_en, .fill_way, .store_en, .lru_touch,
        .hit, .hit_way, .victim_way, .victim_dirty, .victim_tag
    );

    dcache_data_store #(.INDEX_W(INDEX_W)) u_data_store (
        .clk, .addr, .lookup_en, .store_en, .hit_way, .strb, .wdata,
        .beat_valid, .beat_idx, .beat_data, .fill_way, .wb_idx,
        .hit_word, .wb_word
    );

    dcache_axi_master #(.INDEX_W(INDEX_W)) u_axi_master (
        .clk, .rst, .wb_start, .rf_start, .victim_tag, .addr, .wb_word,
        .wb_idx, .wb_done, .rf_done, .beat_valid, .beat_idx, .beat_data,
        .araddr, .arlen, .arvalid, .arready,
        .rdata_m, .rlast, .rvalid, .rready,
        .awaddr, .awlen, .awvalid, .awready,
        .wdata_m, .wstrb, .wlast, .wvalid, .wready,
        .bvalid, .bready
    );

endmodule

`default_nettype wire

// ==== dv/dcache_axi_mem.sv ====
`default_nettype none

module dcache_axi_mem
    import dcache_pkg::*;
#(
    parameter int MEM_BYTES = 8192
) (
    input  logic       clk,
    input  logic       rst,
    input  addr_t      araddr,
    input  logic [7:0] arlen,
    input  logic       arvalid,
    output logic       arready,
    output word_t      rdata_m,
    output logic       rlast,
    output logic       rvalid,
    input  logic       rready,
    input  addr_t      awaddr,
    input  logic       awvalid,
    output logic       awready,
    input  word_t      wdata_m,
    input  strb_t      wstrb,
    input  logic       wlast,
    input  logic       wvalid,
    output logic       wready,
    output logic       bvalid,
    input  logic       bready
);

    timeunit 1ns;
    timeprecision 1ps;

    localparam int AW = $clog2(MEM_BYTES);

    logic [7:0]  mem [MEM_BYTES];
    logic [15:0] lfsr = 16'd82;
    logic        rd_busy;
    logic        r_fire;   // r beat taken at the last rising edge
    logic        b_fire;
    addr_t       rd_addr;
    addr_t       wr_addr;
    logic [7:0]  rd_beat;
    logic [7:0]  rd_len;
    logic [1:0]  wr_phase; // 0 address, 1 data, 2 response

    // ready three times in four
    function automatic logic draw_ready();
        logic b0;
        logic b1;
        b0   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
        lfsr = {lfsr[14:0], b0};
        b1   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
        lfsr = {lfsr[14:0], b1};
        return b0 | b1;
    endfunction

    function automatic word_t read_word(input addr_t a);
        word_t         w;
        logic [AW-1:0] base;
        base = {a[AW-1:2], 2'b00};
        for (int b = 0; b < 4; b++) begin
            w[8*b +: 8] = mem[base + AW'(b)];
        end
        return w;
    endfunction

    initial begin
        word_t w;
        arready = 1'b0;
        rvalid  = 1'b0;
        rlast   = 1'b0;
        rdata_m = '0;
        awready = 1'b0;
        wready  = 1'b0;
        bvalid  = 1'b0;
        for (int i = 0; i < MEM_BYTES / 4; i++) begin
            w = word_t'(i) ^ 32'h5A5A_0000; // word address xor marker
            for (int b = 0; b < 4; b++) begin
                mem[AW'(4 * i + b)] = w[8*b +: 8];
            end
        end
    end

    // handshakes are taken on the rising edge
    always @(posedge clk) begin
        if (rst) begin
            rd_busy  <= 1'b0;
            wr_phase <= 2'd0;
            r_fire   <= 1'b0;
            b_fire   <= 1'b0;
        end else begin
            r_fire <= rvalid && rready;
            b_fire <= bvalid && bready;
            if (arvalid && arready) begin
                rd_busy <= 1'b1;
                rd_addr <= araddr;
                rd_len  <= arlen;
                rd_beat <= 8'd0;
            end
            if (rvalid && rready) begin
                rd_addr <= rd_addr + 32'd4;
                rd_beat <= rd_beat + 8'd1;
                if (rlast) begin
                    rd_busy <= 1'b0;
                end
            end
            if (awvalid && awready) begin
                wr_phase <= 2'd1;
                wr_addr  <= awaddr;
            end
            if (wvalid && wready) begin
                for (int b = 0; b < 4; b++) begin
                    if (wstrb[b]) begin
                        mem[{wr_addr[AW-1:2], 2'b00} + AW'(b)] <= wdata_m[8*b +: 8];
                    end
                end
                wr_addr <= wr_addr + 32'd4;
                if (wlast) begin
                    wr_phase <= 2'd2;
                end
            end
            if (bvalid && bready) begin
                wr_phase <= 2'd0;
            end
        end
    end

    // outputs move on the falling edge
    always @(negedge clk) begin
        if (rst) begin
            arready <= 1'b0;
            rvalid  <= 1'b0;
            rlast   <= 1'b0;
            awready <= 1'b0;
            wready  <= 1'b0;
            bvalid  <= 1'b0;
        end else begin
            arready <= !rd_busy && draw_ready();
            if (!rvalid || r_fire) begin // an offered beat stays until taken
                rvalid  <= rd_busy && draw_ready();
                rdata_m <= read_word(rd_addr);
                rlast   <= (rd_beat == rd_len);
            end
            awready <= (wr_phase == 2'd0) && draw_ready();
            wready  <= (wr_phase == 2'd1) && draw_ready();
            if (!bvalid || b_fire) begin
                bvalid <= (wr_phase == 2'd2) && draw_ready();
            end
        end
    end

endmodule

`default_nettype wire

// ==== dv/dcache_tb.sv ====
`default_nettype none

module dcache_tb
    import dcache_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int MEM_BYTES  = 8192;
    localparam int AW         = $clog2(MEM_BYTES);
    localparam int N_RANDOM   = 60;
    localparam int CYC_PER_OP = 200;

    localparam logic [7:0] BURST_LEN = 8'd7; // eight beats, one line

    typedef enum logic [1:0] {OP_LD, OP_ST, OP_MEM} op_e;

    typedef struct packed {
        op_e   op;
        addr_t addr;
        word_t wdata;
        strb_t strb;
        int    refills; // ar bursts expected, -1 when open
    } entry_t;

    logic  clk   = 1'b0;
    logic  rst   = 1'b1;
    logic  req   = 1'b0;
    strb_t strb  = '0;
    addr_t addr  = '0;
    word_t wdata = '0;
    logic  ack;
    word_t rdata;

    addr_t      araddr;
    addr_t      awaddr;
    logic [7:0] arlen;
    logic [7:0] awlen;
    logic       arvalid, arready, rlast, rvalid, rready;
    logic       awvalid, awready, wlast, wvalid, wready, bvalid, bready;
    word_t      rdata_m, wdata_m;
    strb_t      wstrb;

    entry_t      tests [$];
    logic [7:0]  shadow [MEM_BYTES];
    logic [15:0] lfsr     = 16'd82;
    int          ar_count = 0;
    int          checks   = 0;
    int          errors   = 0;

    always #5 clk = ~clk;

    always @(posedge clk) begin
        if (arvalid && arready) begin
            ar_count++;
            check_len("arlen", arlen, BURST_LEN);
        end
        if (awvalid && awready) begin
            check_len("awlen", awlen, BURST_LEN);
        end
    end

    dcache_top #(.INDEX_W(4)) u_dcache_top (
        .clk, .rst, .req, .strb, .addr, .wdata, .ack, .rdata,
        .araddr, .arlen, .arvalid, .arready, .rdata_m, .rlast, .rvalid, .rready,
        .awaddr, .awlen, .awvalid, .awready, .wdata_m, .wstrb, .wlast, .wvalid, .wready,
        .bvalid, .bready
    );

    dcache_axi_mem #(.MEM_BYTES(MEM_BYTES)) u_mem (
        .clk, .rst,
        .araddr, .arlen, .arvalid, .arready, .rdata_m, .rlast, .rvalid, .rready,
        .awaddr, .awvalid, .awready, .wdata_m, .wstrb, .wlast, .wvalid, .wready,
        .bvalid, .bready
    );

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic step_lfsr();
        logic fb;
        fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
        lfsr = {lfsr[14:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], step_lfsr()};
        end
        return v;
    endfunction

    function automatic word_t shadow_word(input addr_t a);
        word_t         w;
        logic [AW-1:0] base;
        base = {a[AW-1:2], 2'b00};
        for (int b = 0; b < 4; b++) begin
            w[8*b +: 8] = shadow[base + AW'(b)];
        end
        return w;
    endfunction

    function automatic void shadow_write(input addr_t a, input word_t d, input strb_t s);
        logic [AW-1:0] base;
        base = {a[AW-1:2], 2'b00};
        for (int b = 0; b < 4; b++) begin
            if (s[b]) begin
                shadow[base + AW'(b)] = d[8*b +: 8];
            end
        end
    endfunction

    function automatic word_t mem_model_word(input addr_t a);
        word_t         w;
        logic [AW-1:0] base;
        base = {a[AW-1:2], 2'b00};
        for (int b = 0; b < 4; b++) begin
            w[8*b +: 8] = u_mem.mem[base + AW'(b)];
        end
        return w;
    endfunction

    function automatic void add_entry(input op_e op, input addr_t a, input word_t d,
                                      input strb_t s, input int n);
        tests.push_back('{op, a, d, s, n});
    endfunction

    // index is addr[8:5], so lines 0x200 apart share a set
    function automatic void build_table();
        addr_t a;
        word_t d;
        strb_t s;
        add_entry(OP_LD,  32'h024, '0, '0, 1);   // cold load
        add_entry(OP_LD,  32'h03C, '0, '0, 0);
        add_entry(OP_ST,  32'h028, 32'hDEAD_BEEF, 4'b1111, 0);
        add_entry(OP_LD,  32'h028, '0, '0, 0);
        add_entry(OP_ST,  32'h048, 32'h1122_3344, 4'b0101, 1); // merged into refill
        add_entry(OP_LD,  32'h048, '0, '0, 0);
        add_entry(OP_LD,  32'h04C, '0, '0, 0);
        add_entry(OP_LD,  32'h220, '0, '0, 1);
        add_entry(OP_LD,  32'h420, '0, '0, 1);   // dirty line 0x020 goes back
        add_entry(OP_MEM, 32'h028, '0, '0, -1);
        add_entry(OP_LD,  32'h028, '0, '0, 1);
        add_entry(OP_LD,  32'h060, '0, '0, 1);   // lru order A B A C
        add_entry(OP_LD,  32'h260, '0, '0, 1);
        add_entry(OP_LD,  32'h060, '0, '0, 0);
        add_entry(OP_LD,  32'h460, '0, '0, 1);
        add_entry(OP_LD,  32'h060, '0, '0, 0);
        add_entry(OP_LD,  32'h260, '0, '0, 1);   // B was the one evicted
        for (int i = 0; i < N_RANDOM; i++) begin
            a = 32'h0000_1000 | (rand_bits(8) << 2);
            s = strb_t'(rand_bits(4));
            d = rand_bits(32);
            add_entry((s == '0) ? OP_LD : OP_ST, a, d, s, -1);
        end
    endfunction

    task automatic check_word(input string name, input word_t got, input word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED time %0d ns: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        checks++;
        if (got != exp) begin
            errors++;
            $display("CHECK FAILED time %0d ns: %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_len(input string name, input logic [7:0] got,
                             input logic [7:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED time %0d ns: %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    // one four-phase transfer
    task automatic run_access(input addr_t a, input word_t d, input strb_t s,
                              output word_t rd);
        @(negedge clk);
        addr  = a;
        wdata = d;
        strb  = s;
        req   = 1'b1;
        @(negedge clk);
        while (!ack) begin
            @(negedge clk);
        end
        rd  = rdata;
        req = 1'b0;
        while (ack) begin
            @(negedge clk);
        end
    endtask

    initial begin
        @(negedge rst);
        repeat (tests.size() * CYC_PER_OP) @(posedge clk);
        $display("watchdog: run did not end within %0d cycles", tests.size() * CYC_PER_OP);
        $display("TB FAILED");
        $finish;
    end

    initial begin
        entry_t e;
        word_t  w;
        word_t  got;
        int     ar_before;
        int     err_before;
        for (int i = 0; i < MEM_BYTES / 4; i++) begin
            w = word_t'(i) ^ 32'h5A5A_0000;
            for (int b = 0; b < 4; b++) begin
                shadow[AW'(4 * i + b)] = w[8*b +: 8];
            end
        end
        build_table();
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        foreach (tests[i]) begin
            e          = tests[i];
            ar_before  = ar_count;
            err_before = errors;
            case (e.op)
                OP_LD: begin
                    run_access(e.addr, e.wdata, '0, got);
                    check_word("rdata", got, shadow_word(e.addr));
                end
                OP_ST: begin
                    run_access(e.addr, e.wdata, e.strb, got);
                    shadow_write(e.addr, e.wdata, e.strb);
                end
                default: check_word("memory word", mem_model_word(e.addr), shadow_word(e.addr));
            endcase
            if (e.refills >= 0) begin
                check_count("refills", ar_count - ar_before, e.refills);
            end
            $display("entry %0d %s addr %h strb %b: %s", i, e.op.name(), e.addr, e.strb,
                     (errors == err_before) ? "ok" : "mismatch");
        end
        $display("entries %0d checks %0d errors %0d", tests.size(), checks, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== dcache.f ====
rtl/dcache_pkg.sv
rtl/dcache_tag_store.sv
rtl/dcache_data_store.sv
rtl/dcache_ctrl.sv
rtl/dcache_axi_master.sv
rtl/dcache_top.sv
dv/dcache_axi_mem.sv
dv/dcache_tb.sv

// ==== Makefile ====
TOP := dcache_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f dcache.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f dcache.f
	./obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log
	grep -q '^TB PASSED$$' sim.log

clean:
	rm -rf obj_dir sim.log
